//--- Bender.yml
package:
  name: cached_memory

sources:
  - cmem_geom_pkg.sv
  - cmem_ctrl_pkg.sv
  - cache_if.sv
  - dram_if.sv
  - cache_store.sv
  - dram_model.sv
  - access_ctrl.sv
  - cached_memory.sv
  - target: test
    files:
      - tb_cached_memory.sv

//--- access_ctrl.sv
`timescale 1ns/10ps

module access_ctrl #(
  parameter int MEM_LINES_W = cmem_geom_pkg::MEM_LINES_W
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_ren,
  input  logic [cmem_geom_pkg::BYTES_W-1:0] i_wen,
  input  cmem_geom_pkg::addr_t              i_addr,
  input  cmem_geom_pkg::word_t              i_wdata,
  output cmem_geom_pkg::word_t              o_rdata,
  output logic                              o_stall,
  cache_if.ctrl                             cif,
  dram_if.ctrl                              dif
);

  localparam int SEL_W = $clog2(cmem_geom_pkg::WORDS_PER_LINE);

  cmem_ctrl_pkg::ctrl_state_e        state_q;
  cmem_ctrl_pkg::ctrl_state_e        state_d;

  cmem_geom_pkg::addr_t              req_addr;
  logic [cmem_geom_pkg::BYTES_W-1:0] req_be;
  cmem_geom_pkg::word_t              req_wdata;
  cmem_geom_pkg::line_t              saved_line;  // dram read result

  logic                              accept;
  logic [SEL_W-1:0]                  sel;
  cmem_geom_pkg::line_t              src_line;

  assign sel    = req_addr[cmem_geom_pkg::OFFSET_W-1 -: SEL_W];
  assign accept = !o_stall && (i_ren || (i_wen != '0));

  always_comb begin
    case (state_q)
      cmem_ctrl_pkg::ST_IDLE,
      cmem_ctrl_pkg::ST_COMPLETE_READ: o_stall = 1'b0;
      cmem_ctrl_pkg::ST_LOOKUP:        o_stall = !cif.hit;  // miss holds the cpu
      default:                         o_stall = 1'b1;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      cmem_ctrl_pkg::ST_CALIB: begin
        if (dif.ready) state_d = cmem_ctrl_pkg::ST_IDLE;
      end
      cmem_ctrl_pkg::ST_WRITE_ISSUE: begin
        if (!dif.busy) state_d = cmem_ctrl_pkg::ST_IDLE;
      end
      cmem_ctrl_pkg::ST_READ_ISSUE: begin
        if (!dif.busy) state_d = cmem_ctrl_pkg::ST_READ_WAIT;
      end
      cmem_ctrl_pkg::ST_READ_WAIT: begin
        if (dif.rvalid) state_d = cmem_ctrl_pkg::ST_COMPLETE_READ;
      end
      default: begin  // idle, lookup, complete
        if (o_stall) begin
          state_d = cmem_ctrl_pkg::ST_READ_ISSUE;
        end else if (accept) begin
          state_d = i_ren ? cmem_ctrl_pkg::ST_LOOKUP : cmem_ctrl_pkg::ST_WRITE_ISSUE;
        end else begin
          state_d = cmem_ctrl_pkg::ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= cmem_ctrl_pkg::ST_CALIB;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_addr  <= i_addr;
      req_be    <= i_wen;
      req_wdata <= i_wdata;
    end
    if (state_q == cmem_ctrl_pkg::ST_READ_WAIT && dif.rvalid) begin
      saved_line <= dif.rline;
    end
  end

  // lookup and word write are strobed at the accepting edge
  assign cif.lookup      = accept && i_ren;
  assign cif.lookup_addr = i_addr;
  assign cif.wr_en       = accept && !i_ren;
  assign cif.wr_be       = i_wen;
  assign cif.wr_word     = i_wdata;

  assign cif.inst_en   = (state_q == cmem_ctrl_pkg::ST_COMPLETE_READ);
  assign cif.inst_addr = req_addr;
  assign cif.inst_line = saved_line;

  always_comb begin
    case (state_q)
      cmem_ctrl_pkg::ST_WRITE_ISSUE: dif.op = cmem_ctrl_pkg::OP_WRITE;
      cmem_ctrl_pkg::ST_READ_ISSUE:  dif.op = cmem_ctrl_pkg::OP_READ;
      default:                       dif.op = cmem_ctrl_pkg::OP_NONE;
    endcase
  end

  assign dif.laddr = req_addr[cmem_geom_pkg::OFFSET_W +: MEM_LINES_W];

  // word placed at its slot, all other bytes kept
  always_comb begin
    dif.line = '0;
    dif.mask = '1;
    dif.line[sel*cmem_geom_pkg::WORD_W +: cmem_geom_pkg::WORD_W]   = req_wdata;
    dif.mask[sel*cmem_geom_pkg::BYTES_W +: cmem_geom_pkg::BYTES_W] = ~req_be;
  end

  assign src_line = (state_q == cmem_ctrl_pkg::ST_COMPLETE_READ) ? saved_line : cif.rline;
  assign o_rdata  = src_line[sel*cmem_geom_pkg::WORD_W +: cmem_geom_pkg::WORD_W];

endmodule

//--- cache_if.sv
`timescale 1ns/10ps

interface cache_if;

  // lookup and word write share the address
  logic                                lookup;
  cmem_geom_pkg::addr_t                lookup_addr;
  logic                                wr_en;
  logic [cmem_geom_pkg::BYTES_W-1:0]   wr_be;
  cmem_geom_pkg::word_t                wr_word;

  // line install after a miss
  logic                                inst_en;
  cmem_geom_pkg::addr_t                inst_addr;
  cmem_geom_pkg::line_t                inst_line;

  logic                                hit;    // registered
  cmem_geom_pkg::line_t                rline;  // registered

  modport ctrl (
    output lookup, lookup_addr, wr_en, wr_be, wr_word,
    output inst_en, inst_addr, inst_line,
    input  hit, rline
  );

  modport store (
    input  lookup, lookup_addr, wr_en, wr_be, wr_word,
    input  inst_en, inst_addr, inst_line,
    output hit, rline
  );

endinterface

//--- cache_store.sv
`timescale 1ns/10ps

module cache_store #(
  parameter int INDEX_W = cmem_geom_pkg::INDEX_W
) (
  input  logic    i_clk,
  input  logic    i_rst,
  cache_if.store  cif
);

  localparam int NLINES = 2 ** INDEX_W;
  localparam int TAG_W  = cmem_geom_pkg::ADDR_W - INDEX_W - cmem_geom_pkg::OFFSET_W;
  localparam int SEL_W  = $clog2(cmem_geom_pkg::WORDS_PER_LINE);

  logic [NLINES-1:0]    valid_q;
  logic [TAG_W-1:0]     tags [NLINES];
  cmem_geom_pkg::line_t lines [NLINES];

  logic [INDEX_W-1:0]   lidx;
  logic [TAG_W-1:0]     ltag;
  logic [SEL_W-1:0]     lsel;
  logic [INDEX_W-1:0]   iidx;
  logic [TAG_W-1:0]     itag;
  logic                 same_idx;
  logic                 wr_hit;
  logic                 hit_q;
  cmem_geom_pkg::line_t rline_q;

  assign lidx = cif.lookup_addr[cmem_geom_pkg::OFFSET_W +: INDEX_W];
  assign ltag = cif.lookup_addr[cmem_geom_pkg::ADDR_W-1 -: TAG_W];
  assign lsel = cif.lookup_addr[cmem_geom_pkg::OFFSET_W-1 -: SEL_W];
  assign iidx = cif.inst_addr[cmem_geom_pkg::OFFSET_W +: INDEX_W];
  assign itag = cif.inst_addr[cmem_geom_pkg::ADDR_W-1 -: TAG_W];

  assign same_idx = cif.inst_en && (iidx == lidx);

  // a write to a line installed on the same edge must land on the new line
  assign wr_hit = same_idx ? (itag == ltag) : (valid_q[lidx] && (tags[lidx] == ltag));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= '0;
    end else if (cif.inst_en) begin
      valid_q[iidx] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cif.inst_en) begin
      tags[iidx]  <= itag;
      lines[iidx] <= cif.inst_line;
    end
    // after the install so the enabled bytes win
    if (cif.wr_en && wr_hit) begin
      for (int b = 0; b < cmem_geom_pkg::BYTES_W; b++) begin
        if (cif.wr_be[b]) begin
          lines[lidx][lsel*cmem_geom_pkg::WORD_W + b*8 +: 8] <= cif.wr_word[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      hit_q <= 1'b0;
    end else if (cif.lookup) begin
      hit_q <= same_idx ? (itag == ltag) : (valid_q[lidx] && (tags[lidx] == ltag));
    end
  end

  always_ff @(posedge i_clk) begin
    if (cif.lookup) begin
      rline_q <= same_idx ? cif.inst_line : lines[lidx];  // forward a fresh install
    end
  end

  assign cif.hit   = hit_q;
  assign cif.rline = rline_q;

endmodule

//--- cached_memory.sv
`timescale 1ns/10ps

module cached_memory #(
  parameter int INDEX_W      = cmem_geom_pkg::INDEX_W,
  parameter int MEM_LINES_W  = cmem_geom_pkg::MEM_LINES_W,
  parameter int READ_LATENCY = cmem_geom_pkg::READ_LATENCY,
  parameter int CALIB_CYCLES = cmem_geom_pkg::CALIB_CYCLES
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_ren,
  input  logic [cmem_geom_pkg::BYTES_W-1:0] i_wen,
  input  cmem_geom_pkg::addr_t              i_addr,
  input  cmem_geom_pkg::word_t              i_wdata,
  output cmem_geom_pkg::word_t              o_rdata,
  output logic                              o_stall
);

  cache_if cif ();
  dram_if #(.MEM_LINES_W(MEM_LINES_W)) dif ();

  access_ctrl #(
    .MEM_LINES_W (MEM_LINES_W)
  ) access_ctrl_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ren   (i_ren),
    .i_wen   (i_wen),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_rdata (o_rdata),
    .o_stall (o_stall),
    .cif     (cif.ctrl),
    .dif     (dif.ctrl)
  );

  cache_store #(
    .INDEX_W (INDEX_W)
  ) cache_store_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .cif   (cif.store)
  );

  dram_model #(
    .MEM_LINES_W  (MEM_LINES_W),
    .READ_LATENCY (READ_LATENCY),
    .CALIB_CYCLES (CALIB_CYCLES)
  ) dram_model_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .dif   (dif.mem)
  );

endmodule

//--- cmem_ctrl_pkg.sv
package cmem_ctrl_pkg;

  typedef enum logic [2:0] {
    ST_CALIB,
    ST_IDLE,
    ST_LOOKUP,
    ST_WRITE_ISSUE,
    ST_READ_ISSUE,
    ST_READ_WAIT,
    ST_COMPLETE_READ
  } ctrl_state_e;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } dram_op_e;

endpackage

//--- cmem_geom_pkg.sv
package cmem_geom_pkg;

  localparam int ADDR_W         = 32;
  localparam int WORD_W         = 32;
  localparam int BYTES_W        = 4;  // byte enables per word
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_MASK_W    = 16; // set bit keeps the byte
  localparam int OFFSET_W       = 4;

  // defaults for the top level parameters
  localparam int INDEX_W      = 6;
  localparam int MEM_LINES_W  = 10;
  localparam int READ_LATENCY = 15;
  localparam int CALIB_CYCLES = 40;

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [LINE_W-1:0]      line_t;
  typedef logic [LINE_MASK_W-1:0] line_mask_t;
  typedef logic [ADDR_W-1:0]      addr_t;

endpackage

//--- dram_if.sv
`timescale 1ns/10ps

interface dram_if #(
  parameter int MEM_LINES_W = cmem_geom_pkg::MEM_LINES_W
);

  cmem_ctrl_pkg::dram_op_e   op;
  logic [MEM_LINES_W-1:0]    laddr;  // line address
  cmem_geom_pkg::line_t      line;
  cmem_geom_pkg::line_mask_t mask;

  logic                      ready;  // calibration done
  logic                      busy;
  cmem_geom_pkg::line_t      rline;
  logic                      rvalid;

  // a command is taken when op != OP_NONE and busy is low
  modport ctrl (
    output op, laddr, line, mask,
    input  ready, busy, rline, rvalid
  );

  modport mem (
    input  op, laddr, line, mask,
    output ready, busy, rline, rvalid
  );

endinterface

//--- dram_model.sv
`timescale 1ns/10ps

module dram_model #(
  parameter int MEM_LINES_W  = cmem_geom_pkg::MEM_LINES_W,
  parameter int READ_LATENCY = cmem_geom_pkg::READ_LATENCY,
  parameter int CALIB_CYCLES = cmem_geom_pkg::CALIB_CYCLES
) (
  input  logic  i_clk,
  input  logic  i_rst,
  dram_if.mem   dif
);

  localparam int NLINES = 2 ** MEM_LINES_W;
  localparam int CAL_W  = $clog2(CALIB_CYCLES + 2);
  localparam int LAT_W  = $clog2(READ_LATENCY + 1);

  cmem_geom_pkg::line_t   mem [NLINES] = '{default: '0};

  logic [CAL_W-1:0]       cal_cnt;
  logic                   ready;
  logic [LAT_W-1:0]       lat_cnt;
  logic                   pend_q;    // read outstanding
  logic                   rvalid_q;
  logic [MEM_LINES_W-1:0] raddr_q;
  cmem_geom_pkg::line_t   rline_q;
  logic                   take;

  assign ready    = (cal_cnt == CAL_W'(CALIB_CYCLES));
  assign dif.busy = !ready || pend_q || rvalid_q;
  assign take     = (dif.op != cmem_ctrl_pkg::OP_NONE) && !dif.busy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cal_cnt <= '0;
    end else if (!ready) begin
      cal_cnt <= cal_cnt + 1'b1;
    end
  end

  // masked write, commits at the accepting edge
  always_ff @(posedge i_clk) begin
    if (take && dif.op == cmem_ctrl_pkg::OP_WRITE) begin
      for (int b = 0; b < cmem_geom_pkg::LINE_MASK_W; b++) begin
        if (!dif.mask[b]) begin
          mem[dif.laddr][b*8 +: 8] <= dif.line[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend_q   <= 1'b0;
      rvalid_q <= 1'b0;
      lat_cnt  <= '0;
    end else begin
      rvalid_q <= 1'b0;
      if (take && dif.op == cmem_ctrl_pkg::OP_READ) begin
        pend_q  <= 1'b1;
        lat_cnt <= LAT_W'(READ_LATENCY - 1);
      end else if (pend_q) begin
        if (lat_cnt == '0) begin
          pend_q   <= 1'b0;
          rvalid_q <= 1'b1;
        end else begin
          lat_cnt <= lat_cnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (take && dif.op == cmem_ctrl_pkg::OP_READ) begin
      raddr_q <= dif.laddr;
    end
    if (pend_q && lat_cnt == '0) begin
      rline_q <= mem[raddr_q];
    end
  end

  assign dif.ready  = ready;
  assign dif.rvalid = rvalid_q;
  assign dif.rline  = rline_q;

endmodule

//--- tb_cached_memory.sv
`timescale 1ns/10ps

module tb_cached_memory;

  localparam int INDEX_W       = 6;
  localparam int MEM_LINES_W   = 10;
  localparam int READ_LATENCY  = 15;
  localparam int CALIB_CYCLES  = 40;
  localparam int SEED          = 14677;
  localparam int NSETS         = 2 ** INDEX_W;
  localparam int NTAGS         = 2 ** (MEM_LINES_W - INDEX_W);
  localparam int MEM_BYTES     = 2 ** (MEM_LINES_W + cmem_geom_pkg::OFFSET_W);
  localparam int CALIB_TIMEOUT = CALIB_CYCLES + 20;
  localparam int READ_TIMEOUT  = READ_LATENCY + 20;
  localparam int N_RANDOM      = 2000;

  logic                              i_clk;
  logic                              i_rst;
  logic                              i_ren;
  logic [cmem_geom_pkg::BYTES_W-1:0] i_wen;
  cmem_geom_pkg::addr_t              i_addr;
  cmem_geom_pkg::word_t              i_wdata;
  cmem_geom_pkg::word_t              o_rdata;
  logic                              o_stall;

  logic [7:0] ref_mem [MEM_BYTES];  // byte image of the dram
  int         n_checks;
  int         n_errors;
  int         n_timeouts;

  cached_memory #(
    .INDEX_W      (INDEX_W),
    .MEM_LINES_W  (MEM_LINES_W),
    .READ_LATENCY (READ_LATENCY),
    .CALIB_CYCLES (CALIB_CYCLES)
  ) cached_memory_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_ren   (i_ren),
    .i_wen   (i_wen),
    .i_addr  (i_addr),
    .i_wdata (i_wdata),
    .o_rdata (o_rdata),
    .o_stall (o_stall)
  );

  always #10 i_clk = ~i_clk;

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAILED at %0t ns: %s (got %h, expected %h)", $time, msg, actual, expected);
    end
  endtask

  function automatic cmem_geom_pkg::word_t model_word(input cmem_geom_pkg::addr_t a);
    cmem_geom_pkg::word_t w;
    for (int b = 0; b < cmem_geom_pkg::BYTES_W; b++) begin
      w[b*8 +: 8] = ref_mem[a + b];  // little endian
    end
    return w;
  endfunction

  function automatic cmem_geom_pkg::addr_t make_addr(input int unsigned tag,
                                                     input int unsigned idx,
                                                     input int unsigned wrd);
    return (tag << (INDEX_W + cmem_geom_pkg::OFFSET_W)) | (idx << cmem_geom_pkg::OFFSET_W)
           | (wrd << 2);
  endfunction

  // few sets and few tags half of the time, so lines collide
  function automatic cmem_geom_pkg::addr_t rand_addr();
    int unsigned idx;
    int unsigned tag;
    idx = ($urandom % 2 == 0) ? ($urandom % 4) : ($urandom % NSETS);
    tag = ($urandom % 2 == 0) ? ($urandom % 2) : ($urandom % NTAGS);
    return make_addr(tag, idx, $urandom % cmem_geom_pkg::WORDS_PER_LINE);
  endfunction

  // starts and ends at 1 ns after an edge with o_stall low
  task automatic read_word(input cmem_geom_pkg::addr_t addr, output logic hit);
    cmem_geom_pkg::word_t expected;
    int                   cnt;
    expected = model_word(addr);
    i_addr   = addr;
    i_ren    = 1'b1;
    i_wen    = '0;
    @(posedge i_clk);
    #1;
    i_ren = 1'b0;
    hit   = !o_stall;
    cnt   = 0;
    while (o_stall && cnt < READ_TIMEOUT) begin
      @(posedge i_clk);
      #1;
      cnt++;
    end
    if (o_stall) begin
      n_timeouts++;
      $display("timeout: no read data after %0d cycles for address %h", cnt, addr);
    end else begin
      compare_value(o_rdata, expected, $sformatf("read data at %h", addr));
    end
  endtask

  task automatic write_word(input cmem_geom_pkg::addr_t addr,
                            input logic [cmem_geom_pkg::BYTES_W-1:0] be,
                            input cmem_geom_pkg::word_t data);
    i_addr  = addr;
    i_wen   = be;
    i_wdata = data;
    i_ren   = 1'b0;
    @(posedge i_clk);
    #1;
    i_wen = '0;
    for (int b = 0; b < cmem_geom_pkg::BYTES_W; b++) begin
      if (be[b]) ref_mem[addr + b] = data[b*8 +: 8];
    end
    compare_value(o_stall, 1'b1, $sformatf("stall in write issue cycle at %h", addr));
    @(posedge i_clk);
    #1;
    compare_value(o_stall, 1'b0, $sformatf("stall after write issue at %h", addr));
  endtask

  initial begin
    logic                 hit;
    cmem_geom_pkg::addr_t addr;
    cmem_geom_pkg::addr_t addr_a;
    cmem_geom_pkg::addr_t addr_b;
    int unsigned          idx;
    int unsigned          tag_a;
    int unsigned          tag_b;
    int                   cnt;
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_ren      = 1'b0;
    i_wen      = '0;
    i_addr     = '0;
    i_wdata    = '0;
    n_checks   = 0;
    n_errors   = 0;
    n_timeouts = 0;
    void'($urandom(SEED));
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = 8'h00;

    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    compare_value(o_stall, 1'b1, "stall right after reset");
    cnt = 0;
    while (o_stall && cnt < CALIB_TIMEOUT) begin  // calibration
      @(posedge i_clk);
      #1;
      cnt++;
    end
    if (o_stall) begin
      n_timeouts++;
      $display("timeout: o_stall still high %0d cycles after reset release", cnt);
    end

    // memory reads zero before any write
    for (int i = 0; i < 8; i++) read_word(rand_addr(), hit);

    for (int i = 0; i < 30; i++) begin
      addr = rand_addr();
      write_word(addr, 4'($urandom % 15 + 1), $urandom);
      read_word(addr, hit);
    end

    // second touch of a line hits
    for (int i = 0; i < 20; i++) begin
      addr = rand_addr();
      read_word(addr, hit);
      addr[3:2] = 2'($urandom);
      read_word(addr, hit);
      compare_value(hit, 1'b1, $sformatf("hit on second read of line %h", addr));
    end

    for (int i = 0; i < 20; i++) begin
      idx    = $urandom % NSETS;
      tag_a  = $urandom % NTAGS;
      tag_b  = (tag_a + 1 + $urandom % (NTAGS - 1)) % NTAGS;
      addr_a = make_addr(tag_a, idx, $urandom % cmem_geom_pkg::WORDS_PER_LINE);
      addr_b = make_addr(tag_b, idx, $urandom % cmem_geom_pkg::WORDS_PER_LINE);
      read_word(addr_a, hit);
      read_word(addr_b, hit);
      write_word(addr_a, 4'($urandom % 15 + 1), $urandom);  // a was evicted
      read_word({addr_b[31:4], addr_a[3:0]}, hit);  // b keeps its own bytes
      read_word(addr_a, hit);
      write_word(addr_b, 4'($urandom % 15 + 1), $urandom);
      read_word(addr_b, hit);
    end

    for (int i = 0; i < N_RANDOM && n_timeouts == 0; i++) begin
      addr = rand_addr();
      if ($urandom % 2 == 0) begin
        read_word(addr, hit);
      end else begin
        write_word(addr, 4'($urandom % 15 + 1), $urandom);
      end
    end

    $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
cmem_geom_pkg.sv
cmem_ctrl_pkg.sv
cache_if.sv
dram_if.sv
cache_store.sv
dram_model.sv
access_ctrl.sv
cached_memory.sv
tb_cached_memory.sv
